// ==== rtl/st_mem_defines.svh ====
// ============================
// st memory front end constants
// memory size codes, address tags and
// the viking driver detection limit
// ============================

`ifndef ST_MEM_DEFINES_SVH
`define ST_MEM_DEFINES_SVH

// memory size codes from the configuration
`define ST_MEM_512K         3'd0
`define ST_MEM_1M           3'd1
`define ST_MEM_2M           3'd2
`define ST_MEM_4M           3'd3
`define ST_MEM_8M           3'd4
`define ST_MEM_14M          3'd5

// viking card range, address bits 23..18
`define ST_VIKING_TAG_LO    6'b110000
// moved to $e80000 in steroids mode
`define ST_VIKING_TAG_HI    6'b111010

// high viking ram window, address bits 23..19
`define ST_VIKING_WIN_HI    5'b11101

// accesses needed before the driver counts as loaded
`define ST_VIKING_COUNT_MAX 8'hff

// download address tags, bits 23..18 and 23..20
`define ST_TOS192K_TAG      6'b111111
`define ST_TOS256K_TAG      4'he

// rom bank prefixes, bits 23..18
`define ST_ROM_LO_BASE      6'b111000
`define ST_ROM_HI_BASE      6'b111111

`endif

// ==== rtl/st_mem_pkg.sv ====
// ============================
// st memory front end types
// bus vectors and request structs
// shared across the sdram front end
// ============================

package st_mem_pkg;

	// word address, byte bit 0 dropped
	typedef logic [23:1] addr_t;
	typedef logic [15:0] data_t;
	typedef logic [1:0]  slot_t;
	typedef logic [2:0]  mem_size_t;

	// system configuration
	typedef struct packed {
		mem_size_t mem_size;
		logic      viking_en;
		logic      steroids;
		logic      turbo;
	} st_cfg_t;

	// cpu side bus, rom2_n low selects the rom2 bank
	typedef struct packed {
		addr_t addr;
		logic  as_n;
		logic  rom2_n;
	} cpu_bus_t;

	// chipset ram access from the mcu
	typedef struct packed {
		addr_t addr;
		logic  ras_n;
		logic  refresh;
		logic  we_n;
		logic  uds;
		logic  lds;
		data_t wdata;
	} chip_ram_t;

	// rom/cartridge download port
	typedef struct packed {
		addr_t addr;
		data_t data;
		logic  strobe;
		logic  active;
	} dl_port_t;

	// one request towards the sdram controller
	typedef struct packed {
		logic  req;
		logic  we;
		logic  uds;
		logic  lds;
		addr_t addr;
		data_t wdata;
	} sdram_req_t;

endpackage

// ==== rtl/chipset_ram_port.sv ====
// ============================
// chipset ram port
// ras falling edges become sdram requests,
// gated by the configured ram window
// ============================

`timescale 1ns/1ps

`include "st_mem_defines.svh"

module chipset_ram_port (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  st_mem_pkg::st_cfg_t    cfg_i,
	input  st_mem_pkg::chip_ram_t  ram_i,
	input  logic                   viking_en_i,
	output st_mem_pkg::sdram_req_t req_o
);

	logic ras_n_d;
	logic size_ok;
	logic viking_ok;
	logic ram_en;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ras_n_d <= 1'b1;
		end else begin
			ras_n_d <= ram_i.ras_n;
		end
	end

	// st ram window per memory size
	always_comb begin
		case (cfg_i.mem_size)
			`ST_MEM_512K: size_ok = (ram_i.addr[23:19] == 5'b00000);
			`ST_MEM_1M:   size_ok = (ram_i.addr[23:20] == 4'b0000);
			`ST_MEM_2M:   size_ok = (ram_i.addr[23:21] == 3'b000);
			`ST_MEM_4M:   size_ok = (ram_i.addr[23:22] == 2'b00);
			`ST_MEM_8M:   size_ok = ~ram_i.addr[23];
			// everything but the top 2MB
			`ST_MEM_14M:  size_ok = (ram_i.addr[23:21] != 3'b111);
			default:      size_ok = 1'b0;
		endcase
	end

	// viking video memory, c0 or e8 depending on steroids
	assign viking_ok = viking_en_i &&
		(cfg_i.steroids ? (ram_i.addr[23:19] == `ST_VIKING_WIN_HI)
		                : (ram_i.addr[23:18] == `ST_VIKING_TAG_LO));

	assign ram_en = size_ok | viking_ok;

	// falling ras, no refresh
	assign req_o.req   = ras_n_d & ~ram_i.ras_n & ~ram_i.refresh & ram_en;
	assign req_o.we    = ~ram_i.we_n;
	assign req_o.uds   = ram_i.uds;
	assign req_o.lds   = ram_i.lds;
	assign req_o.addr  = ram_i.addr;
	assign req_o.wdata = ram_i.wdata;

endmodule

// ==== rtl/tos_loader.sv ====
// ============================
// tos/cartridge loader
// download strobe toggles become sdram writes,
// tracks a 192K tos and remaps rom2 accesses
// ============================

`timescale 1ns/1ps

`include "st_mem_defines.svh"

module tos_loader (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  st_mem_pkg::dl_port_t   dl_i,
	input  st_mem_pkg::cpu_bus_t   cpu_i,
	input  st_mem_pkg::slot_t      bus_slot_i,
	output st_mem_pkg::sdram_req_t req_o,
	output st_mem_pkg::addr_t      rom_addr_o
);

	logic strobe_d;
	logic data_wr;
	logic tos192k;

	// strobe sampled once per bus cycle, in slot 0
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			strobe_d <= 1'b0;
			data_wr  <= 1'b0;
		end else begin
			data_wr <= (bus_slot_i == 2'd0) && (dl_i.strobe != strobe_d);
			if (bus_slot_i == 2'd0) begin
				strobe_d <= dl_i.strobe;
			end
		end
	end

	// tos size seen from the download address
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tos192k <= 1'b0;
		end else if (dl_i.active) begin
			if (dl_i.addr[23:18] == `ST_TOS192K_TAG) begin
				tos192k <= 1'b1;
			end else if (dl_i.addr[23:20] == `ST_TOS256K_TAG) begin
				tos192k <= 1'b0;
			end
		end
	end

	// full word write of the download data
	assign req_o.req   = data_wr;
	assign req_o.we    = 1'b1;
	assign req_o.uds   = 1'b1;
	assign req_o.lds   = 1'b1;
	assign req_o.addr  = dl_i.addr;
	assign req_o.wdata = dl_i.data;

	// 192K tos lives at fc0000, larger ones at e00000
	always_comb begin
		if (!cpu_i.rom2_n) begin
			if (tos192k) begin
				rom_addr_o = {`ST_ROM_HI_BASE, cpu_i.addr[17:1]};
			end else begin
				rom_addr_o = {`ST_ROM_LO_BASE, cpu_i.addr[17:1]};
			end
		end else begin
			rom_addr_o = cpu_i.addr;
		end
	end

endmodule

// ==== rtl/viking_monitor.sv ====
// ============================
// viking monitor
// counts cpu hits on the viking range and
// enables the card's video reads
// ============================

`timescale 1ns/1ps

`include "st_mem_defines.svh"

module viking_monitor (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  st_mem_pkg::st_cfg_t    cfg_i,
	input  st_mem_pkg::cpu_bus_t   cpu_i,
	input  st_mem_pkg::slot_t      bus_slot_i,
	input  st_mem_pkg::addr_t      vid_addr_i,
	input  logic                   vid_read_i,
	output logic                   viking_en_o,
	output logic                   viking_active_o,
	output st_mem_pkg::sdram_req_t req_o
);

	logic       mem_ok;
	logic       tag_hit;
	logic [7:0] hit_cnt;

	// at most 8MB st ram leaves room at c00000
	assign mem_ok      = (cfg_i.mem_size <= `ST_MEM_8M);
	assign viking_en_o = (cfg_i.viking_en & mem_ok) | cfg_i.steroids;

	assign tag_hit = (cpu_i.addr[23:18] ==
		(cfg_i.steroids ? `ST_VIKING_TAG_HI : `ST_VIKING_TAG_LO));

	// driver presence is judged by repeated accesses, stray probes stay below
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			hit_cnt         <= 8'h00;
			viking_active_o <= 1'b0;
		end else begin
			if ((bus_slot_i == 2'd0) && !cpu_i.as_n && viking_en_o && tag_hit &&
			    (hit_cnt != `ST_VIKING_COUNT_MAX)) begin
				hit_cnt <= hit_cnt + 8'd1;
			end
			viking_active_o <= (hit_cnt == `ST_VIKING_COUNT_MAX);
		end
	end

	// word read of the video address
	assign req_o.req   = viking_active_o & vid_read_i;
	assign req_o.we    = 1'b0;
	assign req_o.uds   = 1'b1;
	assign req_o.lds   = 1'b1;
	assign req_o.addr  = vid_addr_i;
	assign req_o.wdata = '0;

endmodule

// ==== rtl/sdram_slot_arbiter.sv ====
// ============================
// sdram slot arbiter
// maps bus slots to cpu and viking
// and registers one winning request
// ============================

`timescale 1ns/1ps

module sdram_slot_arbiter (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  st_mem_pkg::st_cfg_t    cfg_i,
	input  st_mem_pkg::slot_t      bus_slot_i,
	input  logic                   download_i,
	input  st_mem_pkg::sdram_req_t chip_i,
	input  st_mem_pkg::sdram_req_t load_i,
	input  st_mem_pkg::sdram_req_t video_i,
	output st_mem_pkg::sdram_req_t sdram_o
);

	logic                   cpu_slot;
	logic                   viking_slot;
	st_mem_pkg::sdram_req_t sel_req;

	// turbo gives the cpu two slots and pushes viking to slot 3
	always_comb begin
		if (cfg_i.turbo) begin
			cpu_slot    = (bus_slot_i == 2'd1) || (bus_slot_i == 2'd2);
			viking_slot = (bus_slot_i == 2'd3);
		end else begin
			cpu_slot    = (bus_slot_i == 2'd1);
			viking_slot = (bus_slot_i == 2'd2);
		end
	end

	// download owns the cpu slots while active,
	// even when it has nothing to write
	always_comb begin
		if (cpu_slot && download_i) begin
			sel_req = load_i;
		end else if (viking_slot && video_i.req) begin
			sel_req = video_i;
		end else begin
			sel_req = chip_i;
		end
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			sdram_o <= '0;
		end else begin
			sdram_o <= sel_req;
		end
	end

endmodule

// ==== rtl/st_mem_top.sv ====
// ============================
// st memory front end top
// chipset, loader and viking requesters
// sharing one sdram request port
// ============================

`timescale 1ns/1ps

module st_mem_top (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  st_mem_pkg::st_cfg_t    cfg_i,
	input  st_mem_pkg::slot_t      bus_slot_i,
	input  st_mem_pkg::cpu_bus_t   cpu_i,
	input  st_mem_pkg::chip_ram_t  ram_i,
	input  st_mem_pkg::dl_port_t   dl_i,
	input  st_mem_pkg::addr_t      vid_addr_i,
	input  logic                   vid_read_i,
	output st_mem_pkg::sdram_req_t sdram_o,
	output st_mem_pkg::addr_t      rom_addr_o,
	output logic                   viking_active_o
);

	st_mem_pkg::sdram_req_t chip_req;
	st_mem_pkg::sdram_req_t load_req;
	st_mem_pkg::sdram_req_t video_req;
	logic                   viking_en;

	chipset_ram_port u_chipset_ram_port (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.cfg_i       (cfg_i),
		.ram_i       (ram_i),
		.viking_en_i (viking_en),
		.req_o       (chip_req)
	);

	tos_loader u_tos_loader (
		.clk_32     (clk_32),
		.xsint      (xsint),
		.dl_i       (dl_i),
		.cpu_i      (cpu_i),
		.bus_slot_i (bus_slot_i),
		.req_o      (load_req),
		.rom_addr_o (rom_addr_o)
	);

	viking_monitor u_viking_monitor (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.cfg_i           (cfg_i),
		.cpu_i           (cpu_i),
		.bus_slot_i      (bus_slot_i),
		.vid_addr_i      (vid_addr_i),
		.vid_read_i      (vid_read_i),
		.viking_en_o     (viking_en),
		.viking_active_o (viking_active_o),
		.req_o           (video_req)
	);

	sdram_slot_arbiter u_sdram_slot_arbiter (
		.clk_32     (clk_32),
		.xsint      (xsint),
		.cfg_i      (cfg_i),
		.bus_slot_i (bus_slot_i),
		.download_i (dl_i.active),
		.chip_i     (chip_req),
		.load_i     (load_req),
		.video_i    (video_req),
		.sdram_o    (sdram_o)
	);

endmodule

// ==== testbench/st_mem_props.sv ====
// ============================
// sdram slot arbiter assertions
// slot ownership, write pulse length
// and request state under reset
// ============================

`timescale 1ns/1ps

module st_mem_props (
	input logic                   clk_32,
	input logic                   xsint,
	input st_mem_pkg::st_cfg_t    cfg_i,
	input st_mem_pkg::slot_t      bus_slot_i,
	input st_mem_pkg::sdram_req_t load_i,
	input st_mem_pkg::sdram_req_t video_i,
	input st_mem_pkg::sdram_req_t sdram_o
);

	logic        vik_slot;
	// failed assertions so far
	int unsigned fail_count = 0;

	// viking slot moves to 3 in turbo mode
	assign vik_slot = cfg_i.turbo ? (bus_slot_i == 2'd3) : (bus_slot_i == 2'd2);

	// a video read in its slot never turns into a write
	no_write_in_viking_slot: assert property (
		@(posedge clk_32) disable iff (!xsint)
		(vik_slot && video_i.req) |=> !sdram_o.we
	) else begin
		fail_count++;
		$error("write issued in a viking slot");
	end

	// one strobe toggle gives a single write pulse
	load_pulse_one_cycle: assert property (
		@(posedge clk_32) disable iff (!xsint)
		load_i.req |=> !load_i.req
	) else begin
		fail_count++;
		$error("download write longer than one cycle");
	end

	output_idle_in_reset: assert property (
		@(posedge clk_32)
		!xsint |-> !sdram_o.req
	) else begin
		fail_count++;
		$error("sdram request active during reset");
	end

endmodule

// ==== testbench/tb_st_mem.sv ====
// ============================
// st memory front end testbench
// seeded random stimulus checked
// against a cycle model of the rules
// ============================

`timescale 1ns/1ps

`include "st_mem_defines.svh"

module tb_st_mem;

	localparam int TOTAL_CYCLES = 7300;
	localparam int CYCLE_LIMIT  = 4 * TOTAL_CYCLES;

	logic                   clk_32 = 1'b0;
	logic                   xsint;
	st_mem_pkg::st_cfg_t    cfg;
	st_mem_pkg::slot_t      bus_slot;
	st_mem_pkg::cpu_bus_t   cpu;
	st_mem_pkg::chip_ram_t  ram;
	st_mem_pkg::dl_port_t   dl;
	st_mem_pkg::addr_t      vid_addr;
	logic                   vid_read;
	st_mem_pkg::sdram_req_t sdram_o;
	st_mem_pkg::addr_t      rom_addr_o;
	logic                   viking_active_o;

	integer seed;
	int     cycles;
	logic   dl_mode;
	logic   vik_mode;

	// model state
	logic                   m_ras_d;
	logic                   m_strobe_d;
	logic                   m_data_wr;
	logic                   m_tos192k;
	logic [7:0]             m_cnt;
	logic                   m_active;
	st_mem_pkg::sdram_req_t m_sdram;

	st_mem_top u_dut (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.cfg_i           (cfg),
		.bus_slot_i      (bus_slot),
		.cpu_i           (cpu),
		.ram_i           (ram),
		.dl_i            (dl),
		.vid_addr_i      (vid_addr),
		.vid_read_i      (vid_read),
		.sdram_o         (sdram_o),
		.rom_addr_o      (rom_addr_o),
		.viking_active_o (viking_active_o)
	);

	bind sdram_slot_arbiter st_mem_props u_props (.*);

	initial begin
		forever #10 clk_32 = ~clk_32;
	end

	function automatic logic [31:0] rand32();
		rand32 = $random(seed);
	endfunction

	task automatic stop_run();
		$display("*** FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_req(input st_mem_pkg::sdram_req_t got,
	                         input st_mem_pkg::sdram_req_t exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0t: %s expected %h got %h", $time, what, exp, got);
			stop_run();
		end
	endtask

	task automatic check_addr(input st_mem_pkg::addr_t got,
	                          input st_mem_pkg::addr_t exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0t: %s expected %h got %h", $time, what, exp, got);
			stop_run();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0t: %s expected %b got %b", $time, what, exp, got);
			stop_run();
		end
	endtask

	// st ram window as byte address ranges
	function automatic logic in_window(input st_mem_pkg::st_cfg_t c, input logic ven,
	                                   input st_mem_pkg::addr_t a);
		logic [23:0] b;
		logic [23:0] lim;
		logic        vik;
		b = {a, 1'b0};
		case (c.mem_size)
			`ST_MEM_512K: lim = 24'h080000;
			`ST_MEM_1M:   lim = 24'h100000;
			`ST_MEM_2M:   lim = 24'h200000;
			`ST_MEM_4M:   lim = 24'h400000;
			`ST_MEM_8M:   lim = 24'h800000;
			`ST_MEM_14M:  lim = 24'he00000;
			default:      lim = 24'h000000;
		endcase
		if (c.steroids) begin
			vik = (b >= 24'he80000) && (b < 24'hf00000);
		end else begin
			vik = (b >= 24'hc00000) && (b < 24'hc40000);
		end
		in_window = (b < lim) || (ven && vik);
	endfunction

	function automatic st_mem_pkg::addr_t exp_rom_addr();
		if (cpu.rom2_n) begin
			exp_rom_addr = cpu.addr;
		end else if (m_tos192k) begin
			exp_rom_addr = {`ST_ROM_HI_BASE, cpu.addr[17:1]};
		end else begin
			exp_rom_addr = {`ST_ROM_LO_BASE, cpu.addr[17:1]};
		end
	endfunction

	task automatic model_reset();
		m_ras_d    = 1'b1;
		m_strobe_d = 1'b0;
		m_data_wr  = 1'b0;
		m_tos192k  = 1'b0;
		m_cnt      = 8'h00;
		m_active   = 1'b0;
		m_sdram    = '0;
	endtask

	// one clock of the model on the inputs seen at this edge
	task automatic model_step();
		st_mem_pkg::sdram_req_t chip;
		st_mem_pkg::sdram_req_t load;
		st_mem_pkg::sdram_req_t video;
		logic                   ven;
		logic                   cslot;
		logic                   vslot;
		logic [5:0]             tag;
		ven = (cfg.viking_en && (cfg.mem_size <= `ST_MEM_8M)) || cfg.steroids;
		tag = cfg.steroids ? `ST_VIKING_TAG_HI : `ST_VIKING_TAG_LO;
		chip.req   = m_ras_d && !ram.ras_n && !ram.refresh && in_window(cfg, ven, ram.addr);
		chip.we    = ~ram.we_n;
		chip.uds   = ram.uds;
		chip.lds   = ram.lds;
		chip.addr  = ram.addr;
		chip.wdata = ram.wdata;
		load  = {m_data_wr, 1'b1, 1'b1, 1'b1, dl.addr, dl.data};
		video = {m_active && vid_read, 1'b0, 1'b1, 1'b1, vid_addr, 16'h0000};
		cslot = (bus_slot == 2'd1) || (cfg.turbo && (bus_slot == 2'd2));
		vslot = cfg.turbo ? (bus_slot == 2'd3) : (bus_slot == 2'd2);
		if (cslot && dl.active) begin
			m_sdram = load;
		end else if (vslot && video.req) begin
			m_sdram = video;
		end else begin
			m_sdram = chip;
		end
		m_data_wr = (bus_slot == 2'd0) && (dl.strobe != m_strobe_d);
		if (bus_slot == 2'd0) begin
			m_strobe_d = dl.strobe;
		end
		m_ras_d = ram.ras_n;
		if (dl.active && (dl.addr[23:18] == `ST_TOS192K_TAG)) begin
			m_tos192k = 1'b1;
		end else if (dl.active && (dl.addr[23:20] == `ST_TOS256K_TAG)) begin
			m_tos192k = 1'b0;
		end
		// flag follows the count of the previous cycle
		m_active = (m_cnt == 8'hff);
		if ((bus_slot == 2'd0) && !cpu.as_n && ven && (cpu.addr[23:18] == tag) &&
		    (m_cnt != 8'hff)) begin
			m_cnt = m_cnt + 8'd1;
		end
	endtask

	always @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			model_reset();
		end else begin
			model_step();
		end
	end

	// outputs settle by the falling edge
	always @(negedge clk_32) begin
		check_req(sdram_o, m_sdram, "sdram request");
		check_addr(rom_addr_o, exp_rom_addr(), "rom address");
		check_bit(viking_active_o, m_active, "viking active");
		if (u_dut.u_sdram_slot_arbiter.u_props.fail_count != 0) begin
			$display("an assertion on the slot arbiter failed");
			stop_run();
		end
	end

	always @(posedge clk_32) begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
			stop_run();
		end
	end

	task automatic drive_random();
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] c;
		r = rand32();
		a = rand32();
		d = rand32();
		c = rand32();
		bus_slot     <= bus_slot + 2'd1;
		ram.ras_n    <= r[0];
		ram.refresh  <= (r[2:1] == 2'b00);
		ram.we_n     <= r[3];
		ram.uds      <= r[4];
		ram.lds      <= r[5];
		ram.wdata    <= r[31:16];
		case (a[25:24])
			2'd0:    ram.addr <= a[22:0];
			2'd1:    ram.addr <= {3'b000, a[19:0]};
			2'd2:    ram.addr <= {`ST_VIKING_TAG_LO, a[16:0]};
			default: ram.addr <= {`ST_VIKING_WIN_HI, a[17:0]};
		endcase
		dl.active <= dl_mode;
		dl.strobe <= d[0];
		dl.data   <= d[31:16];
		case (d[3:1])
			3'd0:    dl.addr <= {`ST_TOS192K_TAG, a[16:0]};
			3'd1:    dl.addr <= {`ST_TOS256K_TAG, a[18:0]};
			default: dl.addr <= {a[28:26], d[19:0]};
		endcase
		if (vik_mode) begin
			cpu.addr <= {(cfg.steroids ? `ST_VIKING_TAG_HI : `ST_VIKING_TAG_LO), c[16:0]};
			cpu.as_n <= (c[19:17] == 3'd0);
		end else begin
			cpu.addr <= c[22:0];
			cpu.as_n <= c[23];
		end
		cpu.rom2_n <= c[24];
		vid_addr   <= {c[31:25], r[21:6]};
		vid_read   <= r[22];
	endtask

	task automatic run_cycles(input int n);
		repeat (n) begin
			@(posedge clk_32);
			drive_random();
		end
	endtask

	task automatic apply_reset();
		xsint <= 1'b0;
		run_cycles(10);
		xsint <= 1'b1;
	endtask

	initial begin
		logic [31:0] r;
		seed     = 53;
		dl_mode  = 1'b0;
		vik_mode = 1'b0;
		xsint    = 1'b0;
		cfg      = '0;
		bus_slot = 2'd0;
		cpu      = '0;
		cpu.as_n   = 1'b1;
		cpu.rom2_n = 1'b1;
		ram      = '0;
		ram.ras_n  = 1'b1;
		ram.we_n   = 1'b1;
		dl       = '0;
		vid_addr = '0;
		vid_read = 1'b0;
		run_cycles(10);
		xsint <= 1'b1;
		@(negedge clk_32);
		check_bit(viking_active_o, 1'b0, "viking active after reset");
		check_bit(sdram_o.req, 1'b0, "request after reset");
		// every memory size with download on in every other pass
		for (int s = 0; s < 6; s++) begin
			r = rand32();
			@(posedge clk_32);
			cfg.mem_size  <= s[2:0];
			cfg.viking_en <= r[0];
			cfg.steroids  <= r[1];
			cfg.turbo     <= r[2];
			dl_mode = ~s[0];
			drive_random();
			run_cycles(200);
		end
		// viking detection with turbo and steroids combinations
		dl_mode = 1'b0;
		for (int v = 0; v < 4; v++) begin
			r = rand32();
			@(posedge clk_32);
			cfg.mem_size  <= (r[2:0] > 3'd4) ? 3'd4 : r[2:0];
			cfg.viking_en <= 1'b1;
			cfg.steroids  <= v[1];
			cfg.turbo     <= v[0];
			drive_random();
			apply_reset();
			vik_mode = 1'b1;
			run_cycles(1400);
			@(negedge clk_32);
			check_bit(viking_active_o, 1'b1, "viking active after detection");
			run_cycles(100);
			vik_mode = 1'b0;
		end
		@(negedge clk_32);
		if (u_dut.u_sdram_slot_arbiter.u_props.fail_count == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("an assertion on the slot arbiter failed");
			stop_run();
		end
	end

endmodule

// ==== st_mem.f ====
+incdir+rtl
rtl/st_mem_pkg.sv
rtl/chipset_ram_port.sv
rtl/tos_loader.sv
rtl/viking_monitor.sv
rtl/sdram_slot_arbiter.sv
rtl/st_mem_top.sv
testbench/st_mem_props.sv
testbench/tb_st_mem.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       := tb_st_mem
FILELIST  := st_mem.f
OBJDIR    := obj_dir
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST)) rtl/st_mem_defines.svh
BINARY  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BINARY)
	-./$(BINARY) > $(LOG) 2>&1
	cat $(LOG)
	grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
